// File: matmul_tile.f
+incdir+include
hdl/matmul_pkg.sv
hdl/operand_ram.sv
hdl/tile_ctrl_fsm.sv
hdl/tile_loop_counter.sv
hdl/dot_accum.sv
hdl/matmul_tile_top.sv
verif/matmul_tile_tb.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run of the matmul_tile testbench
# exit status is 0 only when the testbench reports a pass

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f matmul_tile.f \
    --top-module matmul_tile_tb \
    -o matmul_tile_sim \
    || { echo "build failed"; exit 1; }

sim_out=$(./obj_dir/matmul_tile_sim 2>&1)
echo "$sim_out"

echo "$sim_out" | grep -qx "Test passed" \
    && echo "simulation PASS" \
    || { echo "simulation FAIL"; exit 1; }

// File: verif/matmul_tile_tb.sv
// testbench for the matmul_tile engine
// random loads, reference products, tile order, latency, ignored writes and restart
`timescale 1ns/1ps
`default_nettype none

`include "matmul_params.svh"

module matmul_tile_tb import matmul_pkg::*; ();

    localparam int CLK_PERIOD      = 8;
    localparam int SEED            = 32'h97bbb9f2;
    localparam int TILES           = `MM_ROW_PAIRS * `MM_B_COLS;
    localparam int TILE_LATENCY    = `MM_INNER_STEPS + 1;
    // watchdog budget: three runs of eight tiles, the loads and a margin
    localparam int RUNS            = 3;
    localparam int TILE_BUDGET     = 10;
    localparam int LOAD_CYCLES     = RUNS * (`MM_A_DEPTH + `MM_W_DEPTH);
    localparam int MARGIN_CYCLES   = 200;
    localparam int WATCHDOG_CYCLES = RUNS * TILES * TILE_BUDGET + LOAD_CYCLES + MARGIN_CYCLES;
    localparam int DONE_LIMIT      = TILES * TILE_BUDGET + 20;
    localparam int HOLD_CYCLES     = 5;

    logic    clk;
    logic    rst_n;
    logic    start;
    logic    a_wr_en;
    a_addr_t a_wr_addr;
    word_t   a_wr_data;
    logic    w_wr_en;
    w_addr_t w_wr_addr;
    word_t   w_wr_data;
    logic    out_valid;
    acc_t    out_even;
    acc_t    out_odd;
    pair_t   out_pair;
    col_t    out_col;
    logic    done;
    logic    write_open;

    // model copies of the matrices
    elem_t a_mat [`MM_A_ROWS][`MM_INNER_DIM];
    elem_t w_mat [`MM_INNER_DIM][`MM_B_COLS];

    string       test_name;
    int          error_count;
    int          total_results;
    int unsigned cyc;
    int unsigned issue_cycle;
    int unsigned last_valid_cycle;
    logic        issue_seen;
    logic        valid_prev;

    matmul_tile_top i_matmul_tile_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .a_wr_en    (a_wr_en),
        .a_wr_addr  (a_wr_addr),
        .a_wr_data  (a_wr_data),
        .w_wr_en    (w_wr_en),
        .w_wr_addr  (w_wr_addr),
        .w_wr_data  (w_wr_data),
        .out_valid  (out_valid),
        .out_even   (out_even),
        .out_odd    (out_odd),
        .out_pair   (out_pair),
        .out_col    (out_col),
        .done       (done),
        .write_open (write_open)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // failure reporting and compare tasks
    // ----------------------------------------------------------------------
    task automatic stop_sim();
        $display("Test failed");
        $fatal(1, "simulation stopped after an error");
    endtask

    task automatic fail_plain(input string reason);
        error_count++;
        $display("%s: %s", test_name, reason);
        stop_sim();
    endtask

    task automatic check_acc(input string what, input acc_t expected, input acc_t actual);
        if (actual !== expected) begin
            error_count++;
            $display("** Error: %s %s expected %0d actual %0d",
                     test_name, what, expected, actual);
            stop_sim();
        end
    endtask

    task automatic check_pair(input string what, input pair_t expected, input pair_t actual);
        if (actual !== expected) begin
            error_count++;
            $display("** Error: %s %s expected %0d actual %0d",
                     test_name, what, expected, actual);
            stop_sim();
        end
    endtask

    task automatic check_col(input string what, input col_t expected, input col_t actual);
        if (actual !== expected) begin
            error_count++;
            $display("** Error: %s %s expected %0d actual %0d",
                     test_name, what, expected, actual);
            stop_sim();
        end
    endtask

    task automatic check_bit(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            error_count++;
            $display("** Error: %s %s expected %b actual %b",
                     test_name, what, expected, actual);
            stop_sim();
        end
    endtask

    // cycle distances and result counts
    task automatic check_count(input string what, input int expected, input int actual);
        if (actual != expected) begin
            error_count++;
            $display("** Error: %s %s expected %0d actual %0d",
                     test_name, what, expected, actual);
            stop_sim();
        end
    endtask

    // ----------------------------------------------------------------------
    // reference model
    // ----------------------------------------------------------------------
    // dot product of input row and weight column over the inner dimension
    function automatic acc_t ref_dot(input int row, input int column);
        int sum;
        sum = 0;
        for (int k = 0; k < `MM_INNER_DIM; k++) begin
            sum = sum + int'(a_mat[row][k]) * int'(w_mat[k][column]);
        end
        return acc_t'(sum);
    endfunction

    // ----------------------------------------------------------------------
    // result checker, samples mid cycle where outputs are stable
    // ----------------------------------------------------------------------
    always @(negedge clk) begin
        int    idx;
        pair_t exp_pair;
        col_t  exp_col;
        cyc = cyc + 1;
        if (rst_n) begin
            // remember the first issue cycle of each tile
            if (i_matmul_tile_top.issue && !issue_seen) begin
                issue_cycle = cyc;
            end
            issue_seen = i_matmul_tile_top.issue;
            // done comes one cycle after the last result of a run
            if (valid_prev && (total_results % TILES == 0)) begin
                check_bit("done after last result", 1'b1, done);
            end
            if (out_valid) begin
                idx      = total_results % TILES;
                exp_pair = pair_t'(idx / `MM_B_COLS);
                exp_col  = col_t'(idx % `MM_B_COLS);
                check_pair("out_pair", exp_pair, out_pair);
                check_col("out_col", exp_col, out_col);
                check_acc("out_even", ref_dot(2 * int'(exp_pair), int'(exp_col)), out_even);
                check_acc("out_odd", ref_dot(2 * int'(exp_pair) + 1, int'(exp_col)), out_odd);
                check_count("tile latency", TILE_LATENCY, int'(cyc - issue_cycle));
                check_bit("done during result", 1'b0, done);
                if (idx != 0) begin
                    check_bit("result spacing", 1'b1, (cyc - last_valid_cycle) >= TILE_LATENCY);
                end
                last_valid_cycle = cyc;
                total_results    = total_results + 1;
            end
            valid_prev = out_valid;
        end
    end

    // ----------------------------------------------------------------------
    // stimulus helpers
    // ----------------------------------------------------------------------
    task automatic randomize_a();
        for (int r = 0; r < `MM_A_ROWS; r++) begin
            for (int k = 0; k < `MM_INNER_DIM; k++) begin
                a_mat[r][k] = elem_t'($urandom);
            end
        end
    endtask

    task automatic randomize_w();
        for (int k = 0; k < `MM_INNER_DIM; k++) begin
            for (int c = 0; c < `MM_B_COLS; c++) begin
                w_mat[k][c] = elem_t'($urandom);
            end
        end
    endtask

    // row r, step k at address r*steps+k, element j in byte lane j
    task automatic load_a();
        word_t wd;
        check_bit("write_open before input load", 1'b1, write_open);
        for (int r = 0; r < `MM_A_ROWS; r++) begin
            for (int k = 0; k < `MM_INNER_STEPS; k++) begin
                for (int j = 0; j < `MM_CHUNK; j++) begin
                    wd[j*`MM_ELEM_W +: `MM_ELEM_W] = a_mat[r][k*`MM_CHUNK+j];
                end
                a_wr_en   = 1'b1;
                a_wr_addr = a_addr_t'(r * `MM_INNER_STEPS + k);
                a_wr_data = wd;
                @(posedge clk);
                #1;
            end
        end
        a_wr_en = 1'b0;
    endtask

    // column c, step k at address c*steps+k
    task automatic load_w();
        word_t wd;
        check_bit("write_open before weight load", 1'b1, write_open);
        for (int c = 0; c < `MM_B_COLS; c++) begin
            for (int k = 0; k < `MM_INNER_STEPS; k++) begin
                for (int j = 0; j < `MM_CHUNK; j++) begin
                    wd[j*`MM_ELEM_W +: `MM_ELEM_W] = w_mat[k*`MM_CHUNK+j][c];
                end
                w_wr_en   = 1'b1;
                w_wr_addr = w_addr_t'(c * `MM_INNER_STEPS + k);
                w_wr_data = wd;
                @(posedge clk);
                #1;
            end
        end
        w_wr_en = 1'b0;
    endtask

    // start edge, then wait for done
    // write ports stay closed and junk writes are dropped until done
    task automatic run_compute(input logic junk);
        int waited;
        int base;
        base   = total_results;
        waited = 0;
        start  = 1'b1;
        while (!done) begin
            if (waited == DONE_LIMIT) begin
                fail_plain("done did not rise after the start edge");
            end
            @(posedge clk);
            #1;
            waited++;
            if (!done) begin
                check_bit("write_open during compute", 1'b0, write_open);
            end
            if (junk && !done) begin
                a_wr_en   = 1'b1;
                a_wr_addr = a_addr_t'($urandom);
                a_wr_data = word_t'($urandom);
                w_wr_en   = 1'b1;
                w_wr_addr = w_addr_t'($urandom);
                w_wr_data = word_t'($urandom);
            end else begin
                a_wr_en = 1'b0;
                w_wr_en = 1'b0;
            end
        end
        check_count("results per run", TILES, total_results - base);
    endtask

    // done holds while start is high, start low reopens the write phase
    task automatic finish_run();
        int waited;
        repeat (HOLD_CYCLES) begin
            @(posedge clk);
            #1;
            check_bit("done held", 1'b1, done);
            check_bit("no result after done", 1'b0, out_valid);
        end
        start  = 1'b0;
        waited = 0;
        while (done) begin
            if (waited == 10) begin
                fail_plain("done stayed high after start fell");
            end
            @(posedge clk);
            #1;
            waited++;
        end
        check_bit("write_open after restart", 1'b1, write_open);
    endtask

    // ----------------------------------------------------------------------
    // watchdog
    // ----------------------------------------------------------------------
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_plain("watchdog expired before the test finished");
    end

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------
    initial begin
        void'($urandom(SEED));
        test_name        = "reset";
        error_count      = 0;
        total_results    = 0;
        cyc              = 0;
        issue_cycle      = 0;
        last_valid_cycle = 0;
        issue_seen       = 1'b0;
        valid_prev       = 1'b0;
        rst_n            = 1'b0;
        start            = 1'b0;
        a_wr_en          = 1'b0;
        a_wr_addr        = '0;
        a_wr_data        = '0;
        w_wr_en          = 1'b0;
        w_wr_addr        = '0;
        w_wr_data        = '0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // idle with start low
        test_name = "idle";
        check_bit("out_valid after reset", 1'b0, out_valid);
        check_bit("done after reset", 1'b0, done);
        check_bit("write_open after reset", 1'b1, write_open);
        repeat (20) begin
            @(posedge clk);
            #1;
            check_bit("out_valid while idle", 1'b0, out_valid);
        end
        check_count("results while idle", 0, total_results);

        // first run, compute phase writes must not land
        test_name = "first_run";
        randomize_a();
        randomize_w();
        load_a();
        load_w();
        run_compute(1'b1);
        finish_run();

        // restart with new weights only
        test_name = "restart";
        randomize_w();
        load_w();
        run_compute(1'b1);
        finish_run();

        // both matrices new, quiet write ports
        test_name = "reload";
        randomize_a();
        randomize_w();
        load_a();
        load_w();
        run_compute(1'b0);
        finish_run();

        if (error_count == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            stop_sim();
        end
    end

endmodule

`default_nettype wire

// File: hdl/matmul_tile_top.sv
// matmul_tile top level
// controller, loop counter, input and weight RAMs and two-lane accumulator
`timescale 1ns/1ps
`default_nettype none

`include "matmul_params.svh"

module matmul_tile_top import matmul_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire logic    start,
    // input matrix write port
    input  wire logic    a_wr_en,
    input  wire a_addr_t a_wr_addr,
    input  wire word_t   a_wr_data,
    // weight matrix write port
    input  wire logic    w_wr_en,
    input  wire w_addr_t w_wr_addr,
    input  wire word_t   w_wr_data,
    // results
    output logic         out_valid,
    output acc_t         out_even,
    output acc_t         out_odd,
    output pair_t        out_pair,
    output col_t         out_col,
    output logic         done,
    output logic         write_open
);

    // ------------------------------------------------------------------
    // internal nets
    // ------------------------------------------------------------------
    logic    issue;
    logic    tile_next;
    logic    first_step;
    logic    last_step;
    logic    last_tile;
    a_addr_t a_addr_even;
    a_addr_t a_addr_odd;
    w_addr_t w_addr;
    word_t   a_data_even;
    word_t   a_data_odd;
    word_t   w_data;

    // phase control and tile sequencing
    tile_ctrl_fsm i_tile_ctrl_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .last_step    (last_step),
        .last_tile    (last_tile),
        .result_valid (out_valid),
        .write_open   (write_open),
        .issue        (issue),
        .tile_next    (tile_next),
        .done         (done)
    );

    // step, column and row-pair loops plus read addresses
    tile_loop_counter i_tile_loop_counter (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue       (issue),
        .tile_next   (tile_next),
        .a_addr_even (a_addr_even),
        .a_addr_odd  (a_addr_odd),
        .w_addr      (w_addr),
        .first_step  (first_step),
        .last_step   (last_step),
        .last_tile   (last_tile),
        .pair        (out_pair),
        .col         (out_col)
    );

    // input RAM, port a reads the even row and port b the odd row
    operand_ram #(
        .DEPTH  (`MM_A_DEPTH),
        .ADDR_W (`MM_A_ADDR_W)
    ) i_a_ram (
        .clk        (clk),
        .write_open (write_open),
        .wr_en      (a_wr_en),
        .wr_addr    (a_wr_addr),
        .wr_data    (a_wr_data),
        .rd_addr_a  (a_addr_even),
        .rd_addr_b  (a_addr_odd),
        .rd_data_a  (a_data_even),
        .rd_data_b  (a_data_odd)
    );

    // weight RAM, only port a feeds the accumulator
    operand_ram #(
        .DEPTH  (`MM_W_DEPTH),
        .ADDR_W (`MM_W_ADDR_W)
    ) i_w_ram (
        .clk        (clk),
        .write_open (write_open),
        .wr_en      (w_wr_en),
        .wr_addr    (w_wr_addr),
        .wr_data    (w_wr_data),
        .rd_addr_a  (w_addr),
        .rd_addr_b  (w_addr),
        .rd_data_a  (w_data),
        .rd_data_b  ()
    );

    // two-lane dot product
    dot_accum i_dot_accum (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue        (issue),
        .first_step   (first_step),
        .a_even       (a_data_even),
        .a_odd        (a_data_odd),
        .w            (w_data),
        .result_valid (out_valid),
        .acc_even     (out_even),
        .acc_odd      (out_odd)
    );

endmodule

`default_nettype wire

// File: hdl/dot_accum.sv
// two-lane chunk multiply-accumulate
// even and odd input rows share the weight word of each step
`timescale 1ns/1ps
`default_nettype none

`include "matmul_params.svh"

module dot_accum import matmul_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  issue,
    input  wire logic  first_step,
    input  wire word_t a_even,
    input  wire word_t a_odd,
    input  wire word_t w,
    output logic       result_valid,
    output acc_t       acc_even,
    output acc_t       acc_odd
);

    logic issue_d;
    logic first_d;
    acc_t sum_even;
    acc_t sum_odd;

    // dot product of one word pair, elements taken as signed
    function automatic acc_t chunk_dot(input word_t a, input word_t b);
        acc_t  sum;
        acc_t  prod;
        elem_t ea;
        elem_t eb;
        sum = '0;
        for (int j = 0; j < `MM_CHUNK; j++) begin
            ea   = a[j*`MM_ELEM_W +: `MM_ELEM_W];
            eb   = b[j*`MM_ELEM_W +: `MM_ELEM_W];
            prod = ea * eb;
            sum  = sum + prod;
        end
        return sum;
    endfunction

    assign sum_even = chunk_dot(a_even, w);
    assign sum_odd  = chunk_dot(a_odd, w);

    // ------------------------------------------------------------------
    // align issue with the RAM data cycle
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue_d      <= 1'b0;
            first_d      <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            issue_d      <= issue;
            first_d      <= first_step & issue;
            // last data cycle of a tile, results are final next cycle
            result_valid <= issue_d & ~issue;
        end
    end

    // accumulators, loaded on the first step of a tile
    always_ff @(posedge clk) begin
        if (issue_d) begin
            acc_even <= first_d ? sum_even : acc_even + sum_even;
            acc_odd  <= first_d ? sum_odd : acc_odd + sum_odd;
        end
    end

    // one tile never streams more than a full row of words
    a_data_phase_len: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(issue_d) |-> ##(`MM_INNER_STEPS) !issue_d
    );

endmodule

`default_nettype wire

// File: hdl/tile_loop_counter.sv
// loop counters for inner step, output column and row pair
// forms the RAM read addresses of the current step
`timescale 1ns/1ps
`default_nettype none

`include "matmul_params.svh"

module tile_loop_counter import matmul_pkg::*; (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic issue,
    input  wire logic tile_next,
    output a_addr_t   a_addr_even,
    output a_addr_t   a_addr_odd,
    output w_addr_t   w_addr,
    output logic      first_step,
    output logic      last_step,
    output logic      last_tile,
    output pair_t     pair,
    output col_t      col
);

    step_t step;
    logic  last_col;
    logic  last_pair;

    // ------------------------------------------------------------------
    // counters
    // ------------------------------------------------------------------
    // inner step, wraps after the last word of a row
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step <= '0;
        end else if (issue) begin
            step <= last_step ? '0 : step + 1'b1;
        end
    end

    // column is the inner tile loop, pair the outer one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col  <= '0;
            pair <= '0;
        end else if (tile_next) begin
            col <= last_col ? '0 : col + 1'b1;
            if (last_col) begin
                pair <= last_pair ? '0 : pair + 1'b1;
            end
        end
    end

    assign first_step = (step == '0);
    assign last_step  = (step == step_t'(`MM_INNER_STEPS - 1));
    assign last_col   = (col == col_t'(`MM_B_COLS - 1));
    assign last_pair  = (pair == pair_t'(`MM_ROW_PAIRS - 1));
    assign last_tile  = last_col && last_pair;

    // ------------------------------------------------------------------
    // read addresses
    // ------------------------------------------------------------------
    // row*INNER_STEPS+step is a plain concatenation for power of two sizes
    // even row is 2*pair, odd row is 2*pair+1
    assign a_addr_even = {pair, 1'b0, step};
    assign a_addr_odd  = {pair, 1'b1, step};
    assign w_addr      = {col, step};

endmodule

`default_nettype wire

// File: hdl/tile_ctrl_fsm.sv
// tile controller
// separates the write phase from compute, issues tiles and signals done
`timescale 1ns/1ps
`default_nettype none

module tile_ctrl_fsm import matmul_pkg::*; (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic start,
    input  wire logic last_step,
    input  wire logic last_tile,
    input  wire logic result_valid,
    output logic      write_open,
    output logic      issue,
    output logic      tile_next,
    output logic      done
);

    ctrl_state_t state;
    ctrl_state_t state_next;
    logic        start_d;
    logic        start_rise;

    // ------------------------------------------------------------------
    // start edge detection
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_d <= 1'b0;
        end else begin
            start_d <= start;
        end
    end

    assign start_rise = start & ~start_d;

    // ------------------------------------------------------------------
    // state register
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_WAIT_FILL;
        end else begin
            state <= state_next;
        end
    end

    // next state
    always_comb begin
        state_next = state;
        case (state)
            S_WAIT_FILL: begin
                // outside is loading the RAMs
                if (start_rise) begin
                    state_next = S_START;
                end
            end
            S_START: begin
                // one cycle gap, RAM writes are already closed here
                state_next = S_ISSUE;
            end
            S_ISSUE: begin
                if (last_step) begin
                    state_next = S_DRAIN;
                end
            end
            S_DRAIN: begin
                // wait for the accumulator to present the tile
                if (result_valid) begin
                    state_next = last_tile ? S_DONE : S_ISSUE;
                end
            end
            S_DONE: begin
                // start low reopens the write phase for a restart
                if (!start) begin
                    state_next = S_WAIT_FILL;
                end
            end
            default: begin
                state_next = S_WAIT_FILL;
            end
        endcase
    end

    // ------------------------------------------------------------------
    // outputs
    // ------------------------------------------------------------------
    assign write_open = (state == S_WAIT_FILL) || (state == S_DONE);
    assign issue      = (state == S_ISSUE);
    // advance tile counters while the finished tile is on the outputs
    assign tile_next  = (state == S_DRAIN) && result_valid;
    assign done       = (state == S_DONE);

    // reads start only after the write phase has been closed for a cycle
    a_no_issue_in_write: assert property (
        @(posedge clk) disable iff (!rst_n) issue |-> !write_open && !$past(write_open)
    );

    // the accumulator only completes a tile that was fully issued
    a_result_in_drain: assert property (
        @(posedge clk) disable iff (!rst_n) result_valid |-> state == S_DRAIN
    );

endmodule

`default_nettype wire

// File: hdl/operand_ram.sv
// operand RAM with one write port and two registered read ports
// writes only land while the write phase is open
`timescale 1ns/1ps
`default_nettype none

module operand_ram import matmul_pkg::*; #(
    parameter int DEPTH  = 16,
    parameter int ADDR_W = 4
) (
    input  wire logic              clk,
    input  wire logic              write_open,
    input  wire logic              wr_en,
    input  wire logic [ADDR_W-1:0] wr_addr,
    input  wire word_t             wr_data,
    input  wire logic [ADDR_W-1:0] rd_addr_a,
    input  wire logic [ADDR_W-1:0] rd_addr_b,
    output word_t                  rd_data_a,
    output word_t                  rd_data_b
);

    word_t mem [DEPTH];

    // write port, ignored during compute
    always_ff @(posedge clk) begin
        if (write_open && wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read latency of one cycle on both ports
    always_ff @(posedge clk) begin
        rd_data_a <= mem[rd_addr_a];
        rd_data_b <= mem[rd_addr_b];
    end

    // a write must land inside the array at a known address
    a_wr_in_range: assert property (
        @(posedge clk) (write_open && wr_en) |->
            (!$isunknown(wr_addr) && (int'(wr_addr) < DEPTH))
    );

endmodule

`default_nettype wire

// File: hdl/matmul_pkg.sv
// type definitions for the matmul_tile engine
`default_nettype none

`include "matmul_params.svh"

package matmul_pkg;

    // one signed matrix element
    typedef logic signed [`MM_ELEM_W-1:0] elem_t;

    // one RAM word, element j sits at bits j*MM_ELEM_W and up
    typedef logic [`MM_CHUNK*`MM_ELEM_W-1:0] word_t;

    // RAM addresses
    typedef logic [`MM_A_ADDR_W-1:0] a_addr_t;
    typedef logic [`MM_W_ADDR_W-1:0] w_addr_t;

    // loop indices
    typedef logic [$clog2(`MM_INNER_STEPS)-1:0] step_t;
    typedef logic [$clog2(`MM_B_COLS)-1:0] col_t;
    typedef logic [$clog2(`MM_ROW_PAIRS)-1:0] pair_t;

    // accumulator and result
    typedef logic signed [`MM_ACC_W-1:0] acc_t;

    // controller states
    typedef enum logic [2:0] {
        S_WAIT_FILL,
        S_START,
        S_ISSUE,
        S_DRAIN,
        S_DONE
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: include/matmul_params.svh
// size parameters of the tiled matrix-multiply engine
// shared by the package, the RTL and the testbench
`ifndef MATMUL_PARAMS_SVH
`define MATMUL_PARAMS_SVH

// ----------------------------------------------------------------------
// element and word geometry
// ----------------------------------------------------------------------
// signed element width
`define MM_ELEM_W 8
// elements packed into one RAM word
`define MM_CHUNK 4
// inner dimension and words per row or column
`define MM_INNER_DIM 16
`define MM_INNER_STEPS 4

// ----------------------------------------------------------------------
// matrix sizes
// ----------------------------------------------------------------------
`define MM_A_ROWS 4
`define MM_ROW_PAIRS 2
`define MM_B_COLS 4
// wide enough for 16 products of two 8 bit signed values
`define MM_ACC_W 24

// memory depths and address widths
`define MM_A_DEPTH 16
`define MM_W_DEPTH 16
`define MM_A_ADDR_W 4
`define MM_W_ADDR_W 4

`endif
